/* src/simt_pkg.sv */
package simt_pkg;

    // Datapath widths
    localparam int DATA_WIDTH     = 32;
    localparam int IADDR_WIDTH    = 16;
    localparam int DADDR_WIDTH    = 32;
    localparam int IMM_WIDTH      = 16;
    localparam int OPCODE_WIDTH   = 4;
    localparam int NUM_REGS       = 16;
    localparam int REG_ADDR_WIDTH = $clog2(NUM_REGS);

    // Upper bound on warp width, sizes the issue payload
    localparam int MAX_LANES = 8;

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [IADDR_WIDTH-1:0]    iaddr_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_NOP    = 4'd0,
        OP_ADD    = 4'd1,
        OP_SUB    = 4'd2,
        OP_AND    = 4'd3,
        OP_OR     = 4'd4,
        OP_XOR    = 4'd5,
        OP_ADDI   = 4'd6,
        OP_LANEID = 4'd7,
        OP_STORE  = 4'd8,
        OP_BNEZ   = 4'd9,
        OP_HALT   = 4'd10
    } opcode_t;

    // Raw instruction word, opcode in the top nibble
    typedef struct packed {
        logic [OPCODE_WIDTH-1:0] opcode;
        reg_addr_t               rd;
        reg_addr_t               rs1;
        reg_addr_t               rs2;
        logic [IMM_WIDTH-1:0]    imm;
    } instr_t;

    // Decoded instruction plus operands of every lane
    typedef struct packed {
        opcode_t                opcode;
        reg_addr_t              rd;
        data_t                  imm;
        iaddr_t                 pc;
        data_t [MAX_LANES-1:0]  rs1;
        data_t [MAX_LANES-1:0]  rs2;
    } issue_t;

    typedef struct packed {
        logic   halt;
        iaddr_t next_pc;
    } retire_t;

endpackage

/* src/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
    import simt_pkg::*;
(
    input  logic    clk,
    input  logic    reset,

    input  logic    start,
    input  iaddr_t  base_pc,

    output logic    imem_valid,
    output iaddr_t  imem_address,
    input  logic    imem_ready,
    input  instr_t  imem_data,

    output logic    fetch_valid,
    output instr_t  fetch_instr,
    output iaddr_t  fetch_pc,
    input  logic    fetch_ready,

    input  logic    retire_valid,
    input  retire_t retire,

    output logic    done
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_REQUEST,
        F_HOLD,
        F_WAIT_RETIRE
    } fetch_state_t;

    fetch_state_t state;
    iaddr_t       pc;

    assign imem_valid   = state == F_REQUEST;
    assign imem_address = pc;
    assign fetch_valid  = state == F_HOLD;
    assign fetch_pc     = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= F_IDLE;
            pc    <= '0;
            done  <= 1'b0;
        end else begin
            case (state)
                F_IDLE: begin
                    if (start) begin
                        pc    <= base_pc;
                        done  <= 1'b0;
                        state <= F_REQUEST;
                    end
                end
                F_REQUEST: begin
                    if (imem_ready) begin
                        state <= F_HOLD;
                    end
                end
                F_HOLD: begin
                    if (fetch_ready) begin
                        state <= F_WAIT_RETIRE;
                    end
                end
                default: begin
                    // Next pc is only known once the instruction retires
                    if (retire_valid) begin
                        if (retire.halt) begin
                            done  <= 1'b1;
                            state <= F_IDLE;
                        end else begin
                            pc    <= retire.next_pc;
                            state <= F_REQUEST;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (imem_valid && imem_ready) begin
            fetch_instr <= imem_data;
        end
    end

    // Request must stay put until memory takes it
    imem_hold_a: assert property (@(posedge clk) disable iff (reset)
        imem_valid && !imem_ready |=> imem_valid && $stable(imem_address));

endmodule

/* src/decode_read.sv */
`timescale 1ns/1ps

module decode_read
    import simt_pkg::*;
#(
    parameter int LANES = 4
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      fetch_valid,
    input  instr_t                    fetch_instr,
    input  iaddr_t                    fetch_pc,
    output logic                      fetch_ready,

    output logic                      issue_valid,
    output issue_t                    issue,
    input  logic                      issue_ready,

    input  logic                      wb_valid,
    input  logic [REG_ADDR_WIDTH-1:0] wb_rd,
    input  data_t                     wb_data [LANES]
);

    data_t  regs [LANES][NUM_REGS];
    issue_t next_issue;

    // Single instruction in flight, so the slot is empty whenever fetch offers
    assign fetch_ready = !issue_valid;

    always_comb begin
        next_issue = '0;
        // Unknown codes retire as NOP
        if (fetch_instr.opcode > OP_HALT) begin
            next_issue.opcode = OP_NOP;
        end else begin
            next_issue.opcode = opcode_t'(fetch_instr.opcode);
        end
        next_issue.rd  = fetch_instr.rd;
        next_issue.imm = {{(DATA_WIDTH-IMM_WIDTH){fetch_instr.imm[IMM_WIDTH-1]}},
                          fetch_instr.imm};
        next_issue.pc  = fetch_pc;
        // Lanes above LANES stay zero in the payload
        for (int l = 0; l < LANES; l++) begin
            next_issue.rs1[l] = regs[l][fetch_instr.rs1];
            next_issue.rs2[l] = regs[l][fetch_instr.rs2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else if (fetch_valid && fetch_ready) begin
            issue_valid <= 1'b1;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready) begin
            issue <= next_issue;
        end
    end

    // Per-lane register file, r0 is never written so it reads zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int l = 0; l < LANES; l++) begin
                for (int r = 0; r < NUM_REGS; r++) begin
                    regs[l][r] <= '0;
                end
            end
        end else if (wb_valid && wb_rd != '0) begin
            for (int l = 0; l < LANES; l++) begin
                regs[l][wb_rd] <= wb_data[l];
            end
        end
    end

    // Writeback comes from execute while fetch waits for retire
    wb_fetch_excl_a: assert property (@(posedge clk) disable iff (reset)
        !(wb_valid && fetch_valid));

endmodule

/* src/lane_execute.sv */
`timescale 1ns/1ps

module lane_execute
    import simt_pkg::*;
#(
    parameter int LANES = 4
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      issue_valid,
    input  issue_t                    issue,
    output logic                      issue_ready,

    output logic                      wb_valid,
    output logic [REG_ADDR_WIDTH-1:0] wb_rd,
    output data_t                     wb_data [LANES],

    output logic                      retire_valid,
    output retire_t                   retire,

    output logic                      dmem_valid,
    output data_t                     dmem_address,
    output data_t                     dmem_data,
    input  logic                      dmem_ready
);

    localparam int LANE_IDX_WIDTH = (LANES > 1) ? $clog2(LANES) : 1;

    logic                      is_store;
    logic                      writes_reg;
    logic                      last_lane;
    logic                      branch_taken;
    logic [LANE_IDX_WIDTH-1:0] store_lane;
    logic [DADDR_WIDTH-1:0]    store_addr;
    retire_t                   next_retire;

    assign is_store   = issue.opcode == OP_STORE;
    assign writes_reg = issue.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                             OP_ADDI, OP_LANEID};
    assign last_lane  = store_lane == LANE_IDX_WIDTH'(LANES - 1);

    // A store keeps the issue slot until its last lane is written
    assign issue_ready = !is_store || (dmem_ready && last_lane);

    // Per-lane ALU
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            case (issue.opcode)
                OP_ADD:    wb_data[l] = issue.rs1[l] + issue.rs2[l];
                OP_SUB:    wb_data[l] = issue.rs1[l] - issue.rs2[l];
                OP_AND:    wb_data[l] = issue.rs1[l] & issue.rs2[l];
                OP_OR:     wb_data[l] = issue.rs1[l] | issue.rs2[l];
                OP_XOR:    wb_data[l] = issue.rs1[l] ^ issue.rs2[l];
                OP_ADDI:   wb_data[l] = issue.rs1[l] + issue.imm;
                OP_LANEID: wb_data[l] = DATA_WIDTH'(l);
                default:   wb_data[l] = '0;
            endcase
        end
    end

    // Register write lands on the same edge as the retire
    assign wb_valid = issue_valid && issue_ready && writes_reg;
    assign wb_rd    = issue.rd;

    // Branch follows lane 0 only
    assign branch_taken = (issue.opcode == OP_BNEZ) && (issue.rs1[0] != '0);

    always_comb begin
        next_retire.halt = issue.opcode == OP_HALT;
        if (branch_taken) begin
            next_retire.next_pc = issue.pc + issue.imm[IADDR_WIDTH-1:0];
        end else begin
            next_retire.next_pc = issue.pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= issue_valid && issue_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            retire <= next_retire;
        end
    end

    // Store sequencer, one dmem write per lane from lane 0 up
    assign store_addr   = issue.rs1[store_lane] + issue.imm;
    assign dmem_valid   = issue_valid && is_store;
    assign dmem_address = store_addr;
    assign dmem_data    = issue.rs2[store_lane];

    always_ff @(posedge clk) begin
        if (reset) begin
            store_lane <= '0;
        end else if (dmem_valid && dmem_ready) begin
            if (last_lane) begin
                store_lane <= '0;
            end else begin
                store_lane <= store_lane + 1'b1;
            end
        end
    end

    // Write request holds with stable payload until accepted
    dmem_hold_a: assert property (@(posedge clk) disable iff (reset)
        dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_address)
                                      && $stable(dmem_data));

endmodule

/* src/simt_core.sv */
`timescale 1ns/1ps

module simt_core
    import simt_pkg::*;
#(
    parameter int LANES = 4
) (
    input  logic   clk,
    input  logic   reset,

    input  logic   start,
    output logic   done,
    input  iaddr_t base_pc,

    // Instruction memory read port
    output logic   imem_valid,
    output iaddr_t imem_address,
    input  logic   imem_ready,
    input  instr_t imem_data,

    // Data memory write port, one lane per transfer
    output logic   dmem_valid,
    output data_t  dmem_address,
    output data_t  dmem_data,
    input  logic   dmem_ready
);

    logic                      fetch_valid;
    instr_t                    fetch_instr;
    iaddr_t                    fetch_pc;
    logic                      fetch_ready;
    logic                      issue_valid;
    issue_t                    issue;
    logic                      issue_ready;
    logic                      wb_valid;
    logic [REG_ADDR_WIDTH-1:0] wb_rd;
    data_t                     wb_data [LANES];
    logic                      retire_valid;
    retire_t                   retire;

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .base_pc      (base_pc),
        .imem_valid   (imem_valid),
        .imem_address (imem_address),
        .imem_ready   (imem_ready),
        .imem_data    (imem_data),
        .fetch_valid  (fetch_valid),
        .fetch_instr  (fetch_instr),
        .fetch_pc     (fetch_pc),
        .fetch_ready  (fetch_ready),
        .retire_valid (retire_valid),
        .retire       (retire),
        .done         (done)
    );

    decode_read #(
        .LANES (LANES)
    ) u_decode_read (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .fetch_pc    (fetch_pc),
        .fetch_ready (fetch_ready),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    lane_execute #(
        .LANES (LANES)
    ) u_lane_execute (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .retire_valid (retire_valid),
        .retire       (retire),
        .dmem_valid   (dmem_valid),
        .dmem_address (dmem_address),
        .dmem_data    (dmem_data),
        .dmem_ready   (dmem_ready)
    );

endmodule

/* dv/simt_core_tb.sv */
`timescale 1ns/1ps

module simt_core_tb
    import simt_pkg::*;
();

    localparam int    LANES     = 4;
    localparam int    CLK_HALF  = 2;
    localparam string TEST_FILE = "dv/simt_core_tests.txt";

    logic   clk;
    logic   reset;
    logic   start;
    logic   done;
    iaddr_t base_pc;
    logic   imem_valid;
    iaddr_t imem_address;
    logic   imem_ready;
    instr_t imem_data;
    logic   dmem_valid;
    data_t  dmem_address;
    data_t  dmem_data;
    logic   dmem_ready;

    // Expected writes of all tests in one flat list indexed per test
    string       test_name  [$];
    iaddr_t      test_base  [$];
    logic        test_stall [$];
    int          exp_first  [$];
    int          exp_count  [$];
    data_t       exp_addr   [$];
    data_t       exp_data   [$];
    logic [31:0] imem       [65536];

    int          cur_test;
    int          write_count;
    int          error_count;
    int          program_lines;
    int          limit_cycles;
    int          pass_count;
    int          fail_count;
    logic        stall_on;
    logic [31:0] lfsr_state;

    simt_core #(
        .LANES (LANES)
    ) u_simt_core (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .done         (done),
        .base_pc      (base_pc),
        .imem_valid   (imem_valid),
        .imem_address (imem_address),
        .imem_ready   (imem_ready),
        .imem_data    (imem_data),
        .dmem_valid   (dmem_valid),
        .dmem_address (dmem_address),
        .dmem_data    (dmem_data),
        .dmem_ready   (dmem_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    // Right-shifting Galois LFSR
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hA300_0000;
        end
        return state >> 1;
    endfunction

    task automatic draw_bit(output logic value);
        lfsr_state = lfsr_next(lfsr_state);
        value      = lfsr_state[0];
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic load_tests(output logic ok);
        int          fd;
        int          fields;
        int          bad_lines;
        int          flag;
        string       line;
        string       name;
        logic [7:0]  kind;
        logic [31:0] addr;
        logic [31:0] value;
        ok        = 1'b0;
        bad_lines = 0;
        fd        = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) > 0) begin
            kind = (line.len() > 0) ? line.getc(0) : "#";
            case (kind)
                "T": begin
                    fields = $sscanf(line, "T %s %h %d", name, addr, flag);
                    if (fields == 3) begin
                        test_name.push_back(name);
                        test_base.push_back(addr[IADDR_WIDTH-1:0]);
                        test_stall.push_back(flag != 0);
                        exp_first.push_back(exp_addr.size());
                        exp_count.push_back(0);
                    end else begin
                        bad_lines++;
                    end
                end
                "P": begin
                    fields = $sscanf(line, "P %h %h", addr, value);
                    if (fields == 2) begin
                        imem[addr[IADDR_WIDTH-1:0]] = value;
                        program_lines++;
                    end else begin
                        bad_lines++;
                    end
                end
                "E": begin
                    fields = $sscanf(line, "E %h %h", addr, value);
                    if (fields == 2 && exp_count.size() > 0) begin
                        exp_addr.push_back(addr);
                        exp_data.push_back(value);
                        exp_count[exp_count.size()-1]++;
                    end else begin
                        bad_lines++;
                    end
                end
                default: begin
                    // Comments and blank lines
                end
            endcase
        end
        $fclose(fd);
        if (bad_lines > 0) begin
            $display("%0d lines of %s could not be parsed", bad_lines, TEST_FILE);
        end
        ok = test_name.size() > 0 && bad_lines == 0;
    endtask

    // Runs on the falling edge before the transfer completes at the next rising edge
    task automatic record_write();
        int idx;
        idx = exp_first[cur_test] + write_count;
        if (done === 1'b1) begin
            $display("Test %s: write to %h while the core is halted",
                     test_name[cur_test], dmem_address);
            error_count++;
        end
        if (write_count < exp_count[cur_test]) begin
            check_value("dmem_address", exp_addr[idx], dmem_address);
            check_value("dmem_data", exp_data[idx], dmem_data);
        end
        write_count++;
    endtask

    // Memory models driven on the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (stall_on) begin
                draw_bit(imem_ready);
                draw_bit(dmem_ready);
            end else begin
                imem_ready = 1'b1;
                dmem_ready = 1'b1;
            end
            imem_data = imem[imem_address];
            // No instruction fetch once halted
            if (!reset && done === 1'b1) begin
                check_value("imem_valid", '0, data_t'(imem_valid));
            end
            if (!reset && dmem_valid === 1'b1 && dmem_ready) begin
                record_write();
            end
        end
    end

    task automatic run_test(input int idx);
        int errors_before;
        // Shared state changes on the rising edge and the models read it on the falling one
        @(posedge clk);
        cur_test      = idx;
        write_count   = 0;
        stall_on      = test_stall[idx];
        errors_before = error_count;
        @(negedge clk);
        base_pc = test_base[idx];
        start   = 1'b1;
        @(negedge clk);
        start   = 1'b0;
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        // Halted core must stay quiet
        repeat (20) @(negedge clk);
        check_value("done", data_t'(1'b1), data_t'(done));
        @(posedge clk);
        if (write_count != exp_count[idx]) begin
            $display("Test %s: %0d writes seen but %0d expected, so a write is %s",
                     test_name[idx], write_count, exp_count[idx],
                     (write_count < exp_count[idx]) ? "missing" : "extra");
            error_count++;
        end
        if (error_count == errors_before) begin
            pass_count++;
            $display("Test %s: ok, %0d writes", test_name[idx], write_count);
        end else begin
            fail_count++;
            $display("Test %s: failed", test_name[idx]);
        end
    endtask

    initial begin
        logic loaded;
        reset         = 1'b1;
        start         = 1'b0;
        base_pc       = '0;
        imem_ready    = 1'b0;
        imem_data     = '0;
        dmem_ready    = 1'b0;
        stall_on      = 1'b0;
        lfsr_state    = 32'h0d5a8b93;
        cur_test      = 0;
        write_count   = 0;
        error_count   = 0;
        program_lines = 0;
        limit_cycles  = 0;
        pass_count    = 0;
        fail_count    = 0;
        // Unloaded words are HALT tagged with their own address
        for (int addr = 0; addr < 65536; addr++) begin
            imem[addr] = {OP_HALT, 12'h000, addr[15:0]};
        end
        load_tests(loaded);
        if (!loaded) begin
            $display("The tests in %s could not be loaded", TEST_FILE);
            fail_count++;
        end else begin
            limit_cycles = 1000 * test_name.size() + 200 * (exp_addr.size() + program_lines);
            repeat (8) @(negedge clk);
            reset = 1'b0;
            for (int i = 0; i < test_name.size(); i++) begin
                run_test(i);
            end
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", limit_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* dv/simt_core_tests.txt */
# T name base_pc stall | P imem_address instruction | E dmem_address data (hex, stall decimal)
# E lines follow their test line in the order the writes must occur
T arith 0000 0
P 0000 71000000
P 0001 62100005
P 0002 63000100
P 0003 14120000
P 0004 25120000
P 0005 36420000
P 0006 47420000
P 0007 58420000
P 0008 19130000
P 0009 80940000
P 000A 80950004
P 000B 80960008
P 000C 8097000C
P 000D 80980010
P 000E A0000000
E 00000100 00000005
E 00000101 00000007
E 00000102 00000009
E 00000103 0000000B
E 00000104 FFFFFFFB
E 00000105 FFFFFFFB
E 00000106 FFFFFFFB
E 00000107 FFFFFFFB
E 00000108 00000005
E 00000109 00000006
E 0000010A 00000001
E 0000010B 00000008
E 0000010C 00000005
E 0000010D 00000007
E 0000010E 0000000F
E 0000010F 0000000B
E 00000110 00000000
E 00000111 00000001
E 00000112 0000000E
E 00000113 00000003
T zero_reg 0020 0
P 0020 60000007
P 0021 71000000
P 0022 63000200
P 0023 19130000
P 0024 80900000
P 0025 A0000000
E 00000200 00000000
E 00000201 00000000
E 00000202 00000000
E 00000203 00000000
T branch_loop 0040 0
P 0040 72000000
P 0041 61200002
P 0042 63200300
P 0043 80310000
P 0044 63300004
P 0045 6111FFFF
P 0046 9010FFFD
P 0047 A0000000
E 00000300 00000002
E 00000301 00000003
E 00000302 00000004
E 00000303 00000005
E 00000304 00000001
E 00000305 00000002
E 00000306 00000003
E 00000307 00000004
T loop_stalled 0040 1
E 00000300 00000002
E 00000301 00000003
E 00000302 00000004
E 00000303 00000005
E 00000304 00000001
E 00000305 00000002
E 00000306 00000003
E 00000307 00000004

/* list.f */
src/simt_pkg.sv
src/fetch_unit.sv
src/decode_read.sv
src/lane_execute.sv
src/simt_core.sv
dv/simt_core_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the SIMT core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module simt_core_tb -f list.f -o simt_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/simt_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    exit 0
fi
exit 1
